//--- Bender.yml
package:
  name: mastermind

sources:
  - rtl/mastermind_pkg.sv
  - rtl/peg_tick_timer.sv
  - rtl/mastermind_fsm.sv
  - rtl/peg_registers.sv
  - rtl/peg_scorer.sv
  - rtl/seg7_decoder.sv
  - rtl/mastermind_top.sv
  - target: simulation
    files:
      - tb/tb_clock_gen.sv
      - tb/mastermind_tb.sv

//--- list.f
rtl/mastermind_pkg.sv
rtl/peg_tick_timer.sv
rtl/mastermind_fsm.sv
rtl/peg_registers.sv
rtl/peg_scorer.sv
rtl/seg7_decoder.sv
rtl/mastermind_top.sv
tb/tb_clock_gen.sv
tb/mastermind_tb.sv

//--- rtl/mastermind_fsm.sv
module mastermind_fsm import mastermind_pkg::*; (
    input  logic         clock,
    input  logic         resetn,
    input  logic         tick_i,
    input  logic         load_i,
    output logic         code_load_o,
    output logic         guess_load_o,
    output peg_idx_t     peg_sel_o,
    output logic         score_clear_o,
    output logic         score_step_o,
    output score_phase_t score_phase_o,
    output logic         score_done_o
);

    // Mode plus peg index form the state; each mode covers four pegs
    typedef enum logic [2:0] {
        CODE_ENTER,
        CODE_WAIT,
        GUESS_ENTER,
        GUESS_WAIT,
        SCORE_EXACT,
        SCORE_COLOUR,
        SCORE_DONE
    } mode_t;

    mode_t    mode, next_mode;
    peg_idx_t idx, next_idx;

    always_comb begin
        next_mode     = mode;
        next_idx      = idx;
        code_load_o   = 1'b0;
        guess_load_o  = 1'b0;
        score_clear_o = 1'b0;
        score_step_o  = 1'b0;
        score_done_o  = 1'b0;
        score_phase_o = PHASE_EXACT;
        peg_sel_o     = idx;

        case (mode)
            CODE_ENTER: begin
                if (load_i) begin
                    code_load_o = tick_i;
                    next_mode   = CODE_WAIT;
                end
            end
            CODE_WAIT: begin
                // Key release moves to the next peg
                if (!load_i) begin
                    next_idx  = idx + 2'd1;
                    next_mode = (idx == LAST_PEG) ? GUESS_ENTER : CODE_ENTER;
                end
            end
            GUESS_ENTER: begin
                if (load_i) begin
                    guess_load_o  = tick_i;
                    score_clear_o = tick_i && (idx == LAST_PEG);
                    next_mode     = GUESS_WAIT;
                end
            end
            GUESS_WAIT: begin
                if (!load_i) begin
                    next_idx  = idx + 2'd1;
                    next_mode = (idx == LAST_PEG) ? SCORE_EXACT : GUESS_ENTER;
                end
            end
            SCORE_EXACT: begin
                score_step_o = tick_i;
                next_idx     = idx + 2'd1;
                if (idx == LAST_PEG)
                    next_mode = SCORE_COLOUR;
            end
            SCORE_COLOUR: begin
                score_phase_o = PHASE_COLOUR;
                score_step_o  = tick_i;
                next_idx      = idx + 2'd1;
                if (idx == LAST_PEG)
                    next_mode = SCORE_DONE;
            end
            SCORE_DONE: begin
                score_done_o = tick_i;
                next_idx     = '0;
                next_mode    = GUESS_ENTER;   // Next round
            end
            default: begin
                next_mode = CODE_ENTER;
                next_idx  = '0;
            end
        endcase
    end

    // State moves on game ticks only
    always_ff @(posedge clock) begin
        if (!resetn) begin
            mode <= CODE_ENTER;
            idx  <= '0;
        end else if (tick_i) begin
            mode <= next_mode;
            idx  <= next_idx;
        end
    end

endmodule

//--- rtl/mastermind_pkg.sv
package mastermind_pkg;

    // Game geometry
    localparam int NUM_PEGS = 4;
    localparam int PEG_W    = 3;
    localparam int COUNT_W  = 3;   // red, white and round counts

    localparam int PEG_IDX_W = $clog2(NUM_PEGS);

    // One peg colour
    typedef logic [PEG_W-1:0] peg_t;

    // Peg 0 in the low bits, entered first
    typedef peg_t [NUM_PEGS-1:0] peg_word_t;

    typedef logic [PEG_IDX_W-1:0] peg_idx_t;

    localparam peg_idx_t LAST_PEG = peg_idx_t'(NUM_PEGS - 1);

    // Scoring passes
    typedef enum logic {
        PHASE_EXACT,   // red pegs
        PHASE_COLOUR   // white pegs
    } score_phase_t;

endpackage

//--- rtl/mastermind_top.sv
module mastermind_top import mastermind_pkg::*; #(
    parameter int TICK_DIV = 4
) (
    input  logic               clock,
    input  logic               resetn,
    input  logic               load_i,
    input  peg_t               data_i,
    output logic [6:0]         hex0_o,
    output logic [6:0]         hex1_o,
    output logic [6:0]         hex2_o,
    output logic [6:0]         hex3_o,
    output logic [6:0]         hex4_o,
    output logic [6:0]         hex5_o,
    output logic [COUNT_W-1:0] red_o,
    output logic [COUNT_W-1:0] white_o,
    output logic [COUNT_W-1:0] round_o,
    output logic               score_done_o
);

    logic         tick;
    logic         code_load;
    logic         guess_load;
    peg_idx_t     peg_sel;
    logic         score_clear;
    logic         score_step;
    score_phase_t score_phase;
    peg_word_t    code;
    peg_word_t    guess;

    peg_tick_timer #(.TICK_DIV(TICK_DIV)) timer0 (
        .clock  (clock),
        .resetn (resetn),
        .tick_o (tick)
    );

    mastermind_fsm fsm0 (
        .clock         (clock),
        .resetn        (resetn),
        .tick_i        (tick),
        .load_i        (load_i),
        .code_load_o   (code_load),
        .guess_load_o  (guess_load),
        .peg_sel_o     (peg_sel),
        .score_clear_o (score_clear),
        .score_step_o  (score_step),
        .score_phase_o (score_phase),
        .score_done_o  (score_done_o)
    );

    peg_registers regs0 (
        .clock        (clock),
        .resetn       (resetn),
        .data_i       (data_i),
        .code_load_i  (code_load),
        .guess_load_i (guess_load),
        .peg_sel_i    (peg_sel),
        .score_done_i (score_done_o),
        .code_o       (code),
        .guess_o      (guess),
        .round_o      (round_o)
    );

    peg_scorer scorer0 (
        .clock         (clock),
        .resetn        (resetn),
        .code_i        (code),
        .guess_i       (guess),
        .score_clear_i (score_clear),
        .score_step_i  (score_step),
        .score_phase_i (score_phase),
        .peg_sel_i     (peg_sel),
        .red_o         (red_o),
        .white_o       (white_o)
    );

    // Guess pegs on digits 0 to 3, then red and white
    seg7_decoder hex0 (.digit_i({1'b0, guess[0]}), .segments_o(hex0_o));
    seg7_decoder hex1 (.digit_i({1'b0, guess[1]}), .segments_o(hex1_o));
    seg7_decoder hex2 (.digit_i({1'b0, guess[2]}), .segments_o(hex2_o));
    seg7_decoder hex3 (.digit_i({1'b0, guess[3]}), .segments_o(hex3_o));
    seg7_decoder hex4 (.digit_i({1'b0, red_o}),    .segments_o(hex4_o));
    seg7_decoder hex5 (.digit_i({1'b0, white_o}),  .segments_o(hex5_o));

endmodule

//--- rtl/peg_registers.sv
module peg_registers import mastermind_pkg::*; (
    input  logic               clock,
    input  logic               resetn,
    input  peg_t               data_i,
    input  logic               code_load_i,
    input  logic               guess_load_i,
    input  peg_idx_t           peg_sel_i,
    input  logic               score_done_i,
    output peg_word_t          code_o,
    output peg_word_t          guess_o,
    output logic [COUNT_W-1:0] round_o
);

    // Secret code
    always_ff @(posedge clock) begin
        if (!resetn)
            code_o <= '0;
        else if (code_load_i)
            code_o[peg_sel_i] <= data_i;
    end

    // Current guess, shown on the displays
    always_ff @(posedge clock) begin
        if (!resetn)
            guess_o <= '0;
        else if (guess_load_i)
            guess_o[peg_sel_i] <= data_i;
    end

    // Completed rounds, modulo 8
    always_ff @(posedge clock) begin
        if (!resetn)
            round_o <= '0;
        else if (score_done_i)
            round_o <= round_o + 1'b1;   // Wraps 7 to 0
    end

endmodule

//--- rtl/peg_scorer.sv
module peg_scorer import mastermind_pkg::*; (
    input  logic               clock,
    input  logic               resetn,
    input  peg_word_t          code_i,
    input  peg_word_t          guess_i,
    input  logic               score_clear_i,
    input  logic               score_step_i,
    input  score_phase_t       score_phase_i,
    input  peg_idx_t           peg_sel_i,
    output logic [COUNT_W-1:0] red_o,
    output logic [COUNT_W-1:0] white_o
);

    logic [NUM_PEGS-1:0] code_used;
    logic [NUM_PEGS-1:0] guess_used;

    peg_t     code_peg;
    logic     exact_hit;
    logic     colour_hit;
    peg_idx_t colour_idx;

    assign code_peg  = code_i[peg_sel_i];
    assign exact_hit = (code_peg == guess_i[peg_sel_i]);

    // Lowest unused guess peg of the same colour
    always_comb begin
        colour_hit = 1'b0;
        colour_idx = '0;
        for (int i = NUM_PEGS - 1; i >= 0; i--) begin
            if (!guess_used[i] && (guess_i[i] == code_peg)) begin
                colour_hit = 1'b1;
                colour_idx = peg_idx_t'(i);
            end
        end
        if (code_used[peg_sel_i])
            colour_hit = 1'b0;   // Already scored red
    end

    always_ff @(posedge clock) begin
        if (!resetn || score_clear_i) begin
            code_used  <= '0;
            guess_used <= '0;
            red_o      <= '0;
            white_o    <= '0;
        end else if (score_step_i) begin
            case (score_phase_i)
                PHASE_EXACT: begin
                    if (exact_hit) begin
                        red_o                 <= red_o + 1'b1;
                        code_used[peg_sel_i]  <= 1'b1;
                        guess_used[peg_sel_i] <= 1'b1;
                    end
                end
                PHASE_COLOUR: begin
                    if (colour_hit) begin
                        white_o                <= white_o + 1'b1;
                        code_used[peg_sel_i]   <= 1'b1;
                        guess_used[colour_idx] <= 1'b1;
                    end
                end
            endcase
        end
    end

endmodule

//--- rtl/peg_tick_timer.sv
module peg_tick_timer #(
    parameter int TICK_DIV = 4
) (
    input  logic clock,
    input  logic resetn,
    output logic tick_o
);

    localparam int CNT_W = (TICK_DIV > 1) ? $clog2(TICK_DIV) : 1;
    localparam logic [CNT_W-1:0] CNT_LAST = CNT_W'(TICK_DIV - 1);

    logic [CNT_W-1:0] count;

    always_ff @(posedge clock) begin
        if (!resetn) begin
            count  <= '0;
            tick_o <= 1'b0;
        end else if (count == CNT_LAST) begin
            count  <= '0;
            tick_o <= 1'b1;   // One clock wide
        end else begin
            count  <= count + 1'b1;
            tick_o <= 1'b0;
        end
    end

endmodule

//--- rtl/seg7_decoder.sv
module seg7_decoder (
    input  logic [3:0] digit_i,
    output logic [6:0] segments_o
);

    // Active low, segment a in bit 0
    always_comb begin
        case (digit_i)
            4'h0: segments_o = 7'b100_0000;
            4'h1: segments_o = 7'b111_1001;
            4'h2: segments_o = 7'b010_0100;
            4'h3: segments_o = 7'b011_0000;
            4'h4: segments_o = 7'b001_1001;
            4'h5: segments_o = 7'b001_0010;
            4'h6: segments_o = 7'b000_0010;
            4'h7: segments_o = 7'b111_1000;
            4'h8: segments_o = 7'b000_0000;
            4'h9: segments_o = 7'b001_1000;
            4'hA: segments_o = 7'b000_1000;
            4'hB: segments_o = 7'b000_0011;
            4'hC: segments_o = 7'b100_0110;
            4'hD: segments_o = 7'b010_0001;
            4'hE: segments_o = 7'b000_0110;
            4'hF: segments_o = 7'b000_1110;
            default: segments_o = 7'h7f;   // Blank
        endcase
    end

endmodule

//--- tb/mastermind_tb.sv
module mastermind_tb import mastermind_pkg::*; ();

    localparam int TICK_DIV        = 4;
    localparam int DRIVE_DELAY     = 10;
    localparam int HOLD_TICKS      = 3;
    localparam int RELEASE_TICKS   = 3;
    localparam int LONG_HOLD_TICKS = 10;
    localparam int SCORE_TICKS     = 9;   // Release tick to done pulse
    localparam int NUM_ROUNDS      = 16;
    localparam int NUM_PRESSES     = NUM_PEGS * (NUM_ROUNDS + 1);
    localparam int PRESS_TICKS     = 1 + HOLD_TICKS + RELEASE_TICKS;
    localparam int MAX_CYCLES      = (NUM_PRESSES * PRESS_TICKS + LONG_HOLD_TICKS
                                      + NUM_ROUNDS * SCORE_TICKS) * TICK_DIV + 400;

    logic               clock;
    logic               resetn;
    logic               load;
    peg_t               data;
    logic [6:0]         hex0, hex1, hex2, hex3, hex4, hex5;
    logic [COUNT_W-1:0] red;
    logic [COUNT_W-1:0] white;
    logic [COUNT_W-1:0] round_count;
    logic               score_done;

    int          cycles;          // Clocks since reset release
    int          release_cycle;
    int          expected_round;
    peg_word_t   game_code;
    peg_word_t   shown_guess;     // What digits 0 to 3 should show
    logic [31:0] lfsr;

    tb_clock_gen #(.PERIOD(100), .RESET_CYCLES(4)) clkgen0 (
        .clock  (clock),
        .resetn (resetn)
    );

    mastermind_top #(.TICK_DIV(TICK_DIV)) dut0 (
        .clock        (clock),
        .resetn       (resetn),
        .load_i       (load),
        .data_i       (data),
        .hex0_o       (hex0),
        .hex1_o       (hex1),
        .hex2_o       (hex2),
        .hex3_o       (hex3),
        .hex4_o       (hex4),
        .hex5_o       (hex5),
        .red_o        (red),
        .white_o      (white),
        .round_o      (round_count),
        .score_done_o (score_done)
    );

    task automatic stop_on_error();
        $display("Checks failed");
        $fatal(1, "run stopped at first error");
    endtask

    always @(posedge clock) begin
        if (!resetn)
            cycles <= 0;
        else
            cycles <= cycles + 1;
        if (cycles > MAX_CYCLES) begin
            $display("Timeout: run still going after %0d clocks", MAX_CYCLES);
            stop_on_error();
        end
    end

    task automatic check_equal(input string name, input logic [31:0] got,
                               input logic [31:0] exp);
        assert (got === exp) else begin
            $display("FAIL %s: got %0h expected %0h", name, got, exp);
            stop_on_error();
        end
    endtask

    // Game tick runs during the clock after every TICK_DIV-th edge
    function automatic logic in_tick_cycle();
        return (cycles != 0) && (cycles % TICK_DIV == 0);
    endfunction

    task automatic next_tick();
        do begin
            @(posedge clock);
            #DRIVE_DELAY;
        end while (!in_tick_cycle());
    endtask

    function automatic logic [31:0] lfsr_next(input logic [31:0] s);
        return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
    endfunction

    function automatic peg_t random_peg();
        peg_t p;
        for (int b = 0; b < PEG_W; b++) begin
            lfsr = lfsr_next(lfsr);
            p[b] = lfsr[0];
        end
        return p;
    endfunction

    function automatic peg_word_t peg_word(input peg_t p0, input peg_t p1,
                                           input peg_t p2, input peg_t p3);
        peg_word_t w;
        w[0] = p0;
        w[1] = p1;
        w[2] = p2;
        w[3] = p3;
        return w;
    endfunction

    // Active low, segment a in bit 0
    function automatic logic [6:0] seg_pattern(input logic [3:0] digit);
        case (digit)
            4'h0: return 7'h40;
            4'h1: return 7'h79;
            4'h2: return 7'h24;
            4'h3: return 7'h30;
            4'h4: return 7'h19;
            4'h5: return 7'h12;
            4'h6: return 7'h02;
            4'h7: return 7'h78;
            default: return 7'h7f;
        endcase
    endfunction

    function automatic logic [6:0] guess_digit(input int i);
        case (i)
            0: return hex0;
            1: return hex1;
            2: return hex2;
            default: return hex3;
        endcase
    endfunction

    // Standard score with white as the shared colour count less red
    function automatic void ref_score(input peg_word_t code, input peg_word_t guess,
                                      output int red_pegs, output int white_pegs);
        int code_count [1 << PEG_W];
        int guess_count [1 << PEG_W];
        int common;
        red_pegs = 0;
        common   = 0;
        for (int c = 0; c < (1 << PEG_W); c++) begin
            code_count[c]  = 0;
            guess_count[c] = 0;
        end
        for (int i = 0; i < NUM_PEGS; i++) begin
            if (code[i] == guess[i])
                red_pegs++;
            code_count[code[i]]++;
            guess_count[guess[i]]++;
        end
        for (int c = 0; c < (1 << PEG_W); c++)
            common += (code_count[c] < guess_count[c]) ? code_count[c] : guess_count[c];
        white_pegs = common - red_pegs;
    endfunction

    // Data changes after the first tick, so a second load would show
    task automatic press_key(input peg_t colour, input int hold_ticks);
        next_tick();
        data = colour;
        load = 1'b1;
        repeat (hold_ticks) begin
            next_tick();
            data = ~colour;
        end
        load = 1'b0;
        release_cycle = cycles;
        repeat (RELEASE_TICKS) next_tick();
    endtask

    task automatic check_display();
        for (int i = 0; i < NUM_PEGS; i++)
            check_equal($sformatf("hex%0d_o", i), guess_digit(i),
                        seg_pattern({1'b0, shown_guess[i]}));
    endtask

    task automatic wait_score_done();
        int waited;
        waited = 0;
        while (score_done !== 1'b1) begin
            @(posedge clock);
            #DRIVE_DELAY;
            waited++;
            assert (waited <= SCORE_TICKS * TICK_DIV) else begin
                $display("score_done_o did not pulse within %0d clocks",
                         SCORE_TICKS * TICK_DIV);
                stop_on_error();
            end
        end
    endtask

    task automatic enter_code(input peg_word_t code);
        game_code = code;
        for (int i = 0; i < NUM_PEGS; i++) begin
            press_key(code[i], HOLD_TICKS);
            check_display();   // Code stays off the displays
        end
    endtask

    task automatic play_round(input peg_word_t guess, input int first_hold);
        int exp_red;
        int exp_white;
        for (int i = 0; i < NUM_PEGS; i++) begin
            press_key(guess[i], (i == 0) ? first_hold : HOLD_TICKS);
            shown_guess[i] = guess[i];
            check_display();
        end
        wait_score_done();
        check_equal("score_done_o delay", cycles - release_cycle, SCORE_TICKS * TICK_DIV);
        ref_score(game_code, guess, exp_red, exp_white);
        check_equal("red_o", red, exp_red);
        check_equal("white_o", white, exp_white);
        check_equal("hex4_o", hex4, seg_pattern(4'(exp_red)));
        check_equal("hex5_o", hex5, seg_pattern(4'(exp_white)));
        @(posedge clock);
        #DRIVE_DELAY;
        expected_round = (expected_round + 1) % (1 << COUNT_W);   // Wraps 7 to 0
        check_equal("round_o", round_count, expected_round);
        check_equal("score_done_o", score_done, 0);
    endtask

    task automatic check_reset_state();
        check_equal("red_o", red, 0);
        check_equal("white_o", white, 0);
        check_equal("round_o", round_count, 0);
        check_equal("score_done_o", score_done, 0);
        check_display();
    endtask

    task automatic echo_guess_pegs();
        enter_code(peg_word(3'd5, 3'd2, 3'd5, 3'd1));
        play_round(peg_word(3'd3, 3'd6, 3'd0, 3'd5), LONG_HOLD_TICKS);
    endtask

    task automatic win_with_exact_guess();
        play_round(game_code, HOLD_TICKS);
        check_equal("red_o", red, NUM_PEGS);
        check_equal("white_o", white, 0);
    endtask

    task automatic score_repeated_colours();
        peg_word_t cases [5];
        cases[0] = peg_word(3'd2, 3'd5, 3'd1, 3'd5);   // All white
        cases[1] = peg_word(3'd5, 3'd5, 3'd5, 3'd5);   // One colour
        cases[2] = peg_word(3'd0, 3'd3, 3'd4, 3'd6);   // No match
        cases[3] = peg_word(3'd5, 3'd5, 3'd2, 3'd2);
        cases[4] = peg_word(3'd1, 3'd5, 3'd2, 3'd5);
        foreach (cases[i])
            play_round(cases[i], HOLD_TICKS);
    endtask

    task automatic play_random_rounds();
        peg_word_t guess;
        repeat (9) begin
            for (int i = 0; i < NUM_PEGS; i++)
                guess[i] = random_peg();
            play_round(guess, HOLD_TICKS);
        end
    endtask

    initial begin
        load           = 1'b0;
        data           = '0;
        lfsr           = 32'he4e5;
        expected_round = 0;
        shown_guess    = '0;
        game_code      = '0;
        wait (resetn === 1'b1);
        @(posedge clock);
        #DRIVE_DELAY;
        check_reset_state();
        echo_guess_pegs();
        win_with_exact_guess();
        score_repeated_colours();
        play_random_rounds();
        $display("All checks passed");
        $finish;
    end

endmodule

//--- tb/tb_clock_gen.sv
module tb_clock_gen #(
    parameter int PERIOD       = 100,
    parameter int RESET_CYCLES = 4
) (
    output logic clock,
    output logic resetn
);

    initial begin
        clock = 1'b0;
        forever #(PERIOD / 2) clock = ~clock;
    end

    // Released just after the last reset edge
    initial begin
        resetn = 1'b0;
        repeat (RESET_CYCLES) @(posedge clock);
        #1 resetn = 1'b1;
    end

endmodule
